//--- Makefile
TOP := tb_nn_ctrl

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f files.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f -o sim_$(TOP)
	@./obj_dir/sim_$(TOP) | tee /dev/stderr | grep -q "^Result: PASSED$$"

clean:
	rm -rf obj_dir

//--- files.f
verilog/ctx_pkg.sv
verilog/thread_sched.sv
verilog/context_step.sv
verilog/context_ring.sv
verilog/nn_ctrl_top.sv
testbench/ctrl_checker.sv
testbench/tb_nn_ctrl.sv

//--- testbench/ctrl_checker.sv
`timescale 1ns/1ns

module ctrl_checker (
    input logic                                clk_i,
    input logic                                rst_ni,
    input logic [ctx_pkg::NUM_THREADS-1:0]     start_i,
    input logic [ctx_pkg::NUM_THREADS-1:0]     valid_i,
    input logic [ctx_pkg::ADDR_W-1:0]          ob_addr_i,
    input logic [ctx_pkg::ADDR_W-1:0]          ib_r_addr_i,
    input logic                                ob_wr_i,
    input ctx_pkg::thread_t                    ib_r_sel_i,
    input logic [ctx_pkg::ADDR_W-1:0]          wb_w_addr_i,
    input logic [ctx_pkg::ADDR_W-1:0]          wb_r_addr_i,
    input logic                                wb_wr_i,
    input logic                                wb_sel_i,
    input logic [ctx_pkg::ADDR_W-1:0]          kb_r_addr_i,
    input logic                                ex_sel_i,
    input logic [ctx_pkg::OB_SEG_W-1:0]        ml_sel_i,
    input logic                                update_i,
    input logic                                ml_clr_i
);

    import ctx_pkg::*;

    string      test_name = "reset";
    logic       started = 1'b0;
    logic       armed = 1'b0;
    logic [3:0] active = '0;
    logic [3:0] valid_prev = '0;
    int         exp_upd [4];
    int         upd_cnt [4];
    int         wr_cnt [4];
    int         drop_age [4];
    int         test_errs = 0;
    int         pass_count = 0;
    int         fail_count = 0;

    task automatic show_mismatch(string what, int exp_v, int act_v);
        $display("[ERROR] %s: %s expected %0d actual %0d", test_name, what, exp_v, act_v);
        test_errs++;
    endtask

    task automatic raise_fault(string what);
        $display("test %s went wrong: %s at %0t ns", test_name, what, $time);
        test_errs++;
    endtask

    always @(posedge clk_i) begin
        int t;
        int r;
        t = int'(ib_r_sel_i);
        // stage 0 holds the thread stepped right after the tagged one
        r = (t + NUM_THREADS - 1) % NUM_THREADS;
        if (!rst_ni || !started) begin
            // nothing may move before the first job
            if (ob_wr_i || wb_wr_i || wb_sel_i || update_i || ml_clr_i || ex_sel_i
                    || valid_i != '0 || ib_r_addr_i != '0 || kb_r_addr_i != '0) begin
                raise_fault("control line or address active during or right after reset");
            end
        end else if (armed) begin
            if ((wb_w_addr_i >> WB_SEG_W) != (WB_BASE[t] >> WB_SEG_W)) begin
                show_mismatch($sformatf("wb_w_addr window t%0d", t),
                              int'(WB_BASE[t] >> WB_SEG_W), int'(wb_w_addr_i >> WB_SEG_W));
            end
            if ((wb_r_addr_i >> WB_SEG_W) != (WB_BASE[r] >> WB_SEG_W)) begin
                show_mismatch($sformatf("wb_r_addr window t%0d", r),
                              int'(WB_BASE[r] >> WB_SEG_W), int'(wb_r_addr_i >> WB_SEG_W));
            end
            if ((kb_r_addr_i >> WB_SEG_W) != '0) begin
                show_mismatch("kb_r_addr window", 0, int'(kb_r_addr_i >> WB_SEG_W));
            end
            if (update_i) begin
                upd_cnt[t]++;
                if (valid_prev[t]) begin
                    raise_fault($sformatf("update on thread %0d after valid rose", t));
                end
            end
            if (ob_wr_i) begin
                if (wr_cnt[t] >= 8) begin
                    raise_fault($sformatf("more than eight output writes on thread %0d", t));
                end else begin
                    if (int'(ob_addr_i) != int'(OB_BASE[t]) + wr_cnt[t]) begin
                        show_mismatch($sformatf("ob_addr t%0d", t),
                                      int'(OB_BASE[t]) + wr_cnt[t], int'(ob_addr_i));
                    end
                    if (int'(ml_sel_i) != wr_cnt[t]) begin
                        show_mismatch($sformatf("ml_sel t%0d", t),
                                      wr_cnt[t], int'(ml_sel_i));
                    end
                end
                wr_cnt[t]++;
            end
            if (!active[t] && (wb_wr_i || ob_wr_i || update_i)) begin
                raise_fault($sformatf("idle thread %0d drove a write or update", t));
            end
            for (int i = 0; i < 4; i++) begin
                if (valid_i[i] && !active[i]) begin
                    raise_fault($sformatf("valid high on unstarted thread %0d", i));
                end
                if (valid_i[i] && !valid_prev[i] && active[i]) begin
                    if (upd_cnt[i] != exp_upd[i]) begin
                        show_mismatch($sformatf("updates t%0d", i), exp_upd[i], upd_cnt[i]);
                    end
                    if (wr_cnt[i] != 8) begin
                        show_mismatch($sformatf("output writes t%0d", i), 8, wr_cnt[i]);
                    end
                end
                if (valid_prev[i] && !valid_i[i] && start_i[i]) begin
                    raise_fault($sformatf("valid of thread %0d fell while start held", i));
                end
                // valid must release soon after start drops
                if (valid_i[i] && !start_i[i]) begin
                    drop_age[i]++;
                    if (drop_age[i] == 9) begin
                        raise_fault($sformatf("valid of thread %0d stuck after start", i));
                    end
                end
            end
            valid_prev = valid_i;
        end
    end

    task automatic report_test();
        if (test_errs == 0) begin
            pass_count++;
            $display("test %s: ok", test_name);
        end else begin
            fail_count++;
            $display("test %s: failed with %0d errors", test_name, test_errs);
        end
    endtask

    task automatic begin_test(string name, logic [3:0] mask, logic [23:0] exp_v);
        test_name = name;
        test_errs = 0;
        active    = mask;
        started   = 1'b1;
        armed     = 1'b1;
        for (int i = 0; i < 4; i++) begin
            exp_upd[i]  = int'(exp_v[i*6 +: 6]);
            upd_cnt[i]  = 0;
            wr_cnt[i]   = 0;
            drop_age[i] = 0;
        end
    endtask

    task automatic end_test();
        armed = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (upd_cnt[i] != exp_upd[i]) begin
                show_mismatch($sformatf("total updates t%0d", i), exp_upd[i], upd_cnt[i]);
            end
            if (wr_cnt[i] != (active[i] ? 8 : 0)) begin
                show_mismatch($sformatf("total writes t%0d", i), active[i] ? 8 : 0, wr_cnt[i]);
            end
        end
        if (valid_i != '0) begin
            raise_fault("valid still high at end of test");
        end
        report_test();
    endtask

    task automatic print_summary();
        $display("tests done: %0d passed, %0d failed", pass_count, fail_count);
    endtask

endmodule

//--- testbench/ctrl_stimulus.txt
# name mask(hex) size0 size1 size2 size3 exp_upd0 exp_upd1 exp_upd2 exp_upd3
# exp_upd is the number of update pulses expected per thread, zero for idle threads
single_t0   1 2 3 1 0 2 0 0 0
single_t1   2 2 3 1 0 0 3 0 0
single_t2   4 2 3 1 0 0 0 1 0
single_t3   8 2 3 1 0 0 0 0 0
pair_t0_t2  5 2 3 1 0 2 0 1 0
all_four    f 2 3 1 0 2 3 1 0
pair_t1_t3  a 1 1 2 2 0 1 0 2

//--- testbench/tb_nn_ctrl.sv
`timescale 1ns/1ns

module tb_nn_ctrl;

    import ctx_pkg::*;

    localparam int MAX_TESTS = 32;

    logic        clk;
    logic        rst_n;
    logic [3:0]  start;
    logic [23:0] iter_size;
    logic [3:0]  valid;
    logic [9:0]  ob_addr;
    logic [9:0]  ib_r_addr;
    logic        ob_wr;
    thread_t     ib_r_sel;
    logic [9:0]  wb_w_addr;
    logic [9:0]  wb_r_addr;
    logic        wb_wr;
    logic        wb_sel;
    logic [9:0]  kb_r_addr;
    logic        ex_sel;
    logic [2:0]  ml_sel;
    logic        update;
    logic        ml_clr;

    string       names [MAX_TESTS];
    logic [3:0]  masks [MAX_TESTS];
    logic [23:0] sizes [MAX_TESTS];
    logic [23:0] exps [MAX_TESTS];
    int          n_tests = 0;
    int          cycle_limit = 0;
    int          cycles = 0;

    nn_ctrl_top i_dut (
        .clk_i       (clk),
        .rst_ni      (rst_n),
        .start_i     (start),
        .iter_size_i (iter_size),
        .valid_o     (valid),
        .ob_addr_o   (ob_addr),
        .ib_r_addr_o (ib_r_addr),
        .ob_wr_o     (ob_wr),
        .ib_r_sel_o  (ib_r_sel),
        .wb_w_addr_o (wb_w_addr),
        .wb_r_addr_o (wb_r_addr),
        .wb_wr_o     (wb_wr),
        .wb_sel_o    (wb_sel),
        .kb_r_addr_o (kb_r_addr),
        .ex_sel_o    (ex_sel),
        .ml_sel_o    (ml_sel),
        .update_o    (update),
        .ml_clr_o    (ml_clr)
    );

    ctrl_checker i_chk (
        .clk_i       (clk),
        .rst_ni      (rst_n),
        .start_i     (start),
        .valid_i     (valid),
        .ob_addr_i   (ob_addr),
        .ib_r_addr_i (ib_r_addr),
        .ob_wr_i     (ob_wr),
        .ib_r_sel_i  (ib_r_sel),
        .wb_w_addr_i (wb_w_addr),
        .wb_r_addr_i (wb_r_addr),
        .wb_wr_i     (wb_wr),
        .wb_sel_i    (wb_sel),
        .kb_r_addr_i (kb_r_addr),
        .ex_sel_i    (ex_sel),
        .ml_sel_i    (ml_sel),
        .update_i    (update),
        .ml_clr_i    (ml_clr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("timeout: a job did not finish within %0d cycles", cycle_limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic read_stimulus();
        int    fd;
        int    n;
        int    m;
        int    s [4];
        int    e [4];
        string line;
        string nm;
        fd = $fopen("testbench/ctrl_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open testbench/ctrl_stimulus.txt");
        end else begin
            while (!$feof(fd) && n_tests < MAX_TESTS) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.getc(0) != 8'h23) begin
                    n = $sscanf(line, "%s %h %d %d %d %d %d %d %d %d", nm, m,
                                s[0], s[1], s[2], s[3], e[0], e[1], e[2], e[3]);
                    if (n == 10) begin
                        names[n_tests] = nm;
                        masks[n_tests] = 4'(m);
                        sizes[n_tests] = {6'(s[3]), 6'(s[2]), 6'(s[1]), 6'(s[0])};
                        exps[n_tests]  = {6'(e[3]), 6'(e[2]), 6'(e[1]), 6'(e[0])};
                        n_tests++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // budget per test grows with its longest job
    function automatic int test_budget(logic [23:0] sz);
        int biggest;
        biggest = 0;
        for (int i = 0; i < 4; i++) begin
            if (int'(sz[i*6 +: 6]) > biggest) begin
                biggest = int'(sz[i*6 +: 6]);
            end
        end
        return 4 * 64 * (biggest + 2);
    endfunction

    task automatic run_test(int k);
        @(negedge clk);
        iter_size = sizes[k];
        i_chk.begin_test(names[k], masks[k], exps[k]);
        start = masks[k];
        while ((valid & masks[k]) != masks[k]) begin
            @(negedge clk);
        end
        // valid has to stay up while start is held
        repeat (6) @(negedge clk);
        start = '0;
        while ((valid & masks[k]) != '0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        i_chk.end_test();
    endtask

    initial begin
        int limit;
        start     = '0;
        iter_size = '0;
        rst_n     = 1'b0;
        read_stimulus();
        limit = 200;
        for (int k = 0; k < n_tests; k++) begin
            limit += test_budget(sizes[k]);
        end
        cycle_limit = limit;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        repeat (8) @(negedge clk);
        i_chk.report_test();
        for (int k = 0; k < n_tests; k++) begin
            run_test(k);
        end
        i_chk.print_summary();
        if (i_chk.fail_count == 0 && n_tests > 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/context_ring.sv
`timescale 1ns/1ns

module context_ring (
    input  logic          clk_i,
    input  logic          rst_ni,
    input  ctx_pkg::ctx_t ctx_next_i,
    output ctx_pkg::ctx_t ctx_s0_o,
    output ctx_pkg::ctx_t ctx_s1_o,
    output ctx_pkg::ctx_t ctx_last_o
);

    import ctx_pkg::*;

    ctx_t stage_q [NUM_THREADS];

    // stage k starts out holding thread k
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < NUM_THREADS; i++) begin
                stage_q[i] <= ctx_reset(thread_t'(i));
            end
        end else begin
            stage_q[0] <= ctx_next_i;
            for (int i = 1; i < NUM_THREADS; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign ctx_s0_o   = stage_q[0];
    assign ctx_s1_o   = stage_q[1];
    assign ctx_last_o = stage_q[NUM_THREADS-1];

    // every state fed back by the step logic is a legal one
    a_state_legal : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        stage_q[0].state inside {IDLE, START, CLEAR, ML, UPDATE, IB_BACK, VALID}
    );

endmodule

//--- verilog/context_step.sv
`timescale 1ns/1ns

module context_step (
    input  ctx_pkg::ctx_t              ctx_last_i,
    input  ctx_pkg::thread_t           phase_i,
    input  logic                       start_i,
    input  logic [ctx_pkg::CNT_W-1:0]  iter_size_i,
    output ctx_pkg::ctx_t              ctx_next_o,
    output logic                       valid_set_o,
    output logic                       valid_clr_o
);

    import ctx_pkg::*;

    logic in_load;
    logic at_last;

    // advance only the low segment, the base bits stay put
    function automatic logic [ADDR_W-1:0] seg_inc(logic [ADDR_W-1:0] addr);
        return {addr[ADDR_W-1:WB_SEG_W], addr[WB_SEG_W-1:0] + WB_SEG_W'(1)};
    endfunction

    function automatic logic [ADDR_W-1:0] seg_set(logic [ADDR_W-1:0] addr,
                                                  logic [WB_SEG_W-1:0] low);
        return {addr[ADDR_W-1:WB_SEG_W], low};
    endfunction

    assign in_load = (ctx_last_i.cnt <= LOAD_LAST);
    assign at_last = (ctx_last_i.cnt == SWEEP_LAST);

    always_comb begin
        ctx_next_o  = ctx_last_i;
        valid_set_o = 1'b0;
        valid_clr_o = 1'b0;

        case (ctx_last_i.state)
            IDLE: begin
                valid_clr_o          = 1'b1;
                ctx_next_o.state     = start_i ? START : IDLE;
                ctx_next_o.iter      = iter_size_i;
                ctx_next_o.cnt       = '0;
                ctx_next_o.ib_addr   = '0;
                ctx_next_o.ob_addr   = {ctx_last_i.ob_addr[ADDR_W-1:OB_SEG_W], OB_SEG_W'(0)};
                ctx_next_o.ob_wr     = 1'b0;
                ctx_next_o.ib_sel    = phase_i;
                ctx_next_o.wb_w_addr = seg_set(ctx_last_i.wb_w_addr, '0);
                ctx_next_o.wb_r_addr = seg_set(ctx_last_i.wb_r_addr, '0);
                ctx_next_o.wb_wr     = 1'b0;
                ctx_next_o.wb_sel    = 1'b0;
                ctx_next_o.kb_r_addr = '0;
                ctx_next_o.ex_sel    = 1'b0;
                ctx_next_o.ml_sel    = '0;
                ctx_next_o.update    = 1'b0;
                ctx_next_o.ml_clr    = 1'b0;
            end

            START: begin
                // read windows sit one below the first word
                ctx_next_o.state     = CLEAR;
                ctx_next_o.wb_w_addr = seg_set(ctx_last_i.wb_w_addr, '0);
                ctx_next_o.wb_r_addr = seg_set(ctx_last_i.wb_r_addr, '1);
                ctx_next_o.kb_r_addr = seg_set(ctx_last_i.kb_r_addr, '1);
                ctx_next_o.wb_wr     = 1'b1;
                ctx_next_o.ex_sel    = 1'b1;
                ctx_next_o.update    = 1'b0;
                ctx_next_o.ml_sel    = '0;
                ctx_next_o.ml_clr    = 1'b1;
            end

            CLEAR: begin
                ctx_next_o.state     = ML;
                ctx_next_o.ib_addr   = ctx_last_i.ib_addr + ADDR_W'(1);
                ctx_next_o.wb_w_addr = seg_inc(ctx_last_i.wb_w_addr);
                ctx_next_o.wb_r_addr = seg_inc(ctx_last_i.wb_r_addr);
                ctx_next_o.kb_r_addr = seg_inc(ctx_last_i.kb_r_addr);
                ctx_next_o.wb_wr     = 1'b1;
                ctx_next_o.wb_sel    = 1'b0;
                ctx_next_o.ex_sel    = 1'b0;
                ctx_next_o.update    = 1'b0;
                ctx_next_o.ml_sel    = '0;
                ctx_next_o.ml_clr    = 1'b1;
                ctx_next_o.cnt       = ctx_last_i.cnt + CNT_W'(1);
            end

            ML: begin
                // input streams in first, then the array executes
                if (in_load || at_last) begin
                    ctx_next_o.wb_sel  = 1'b0;
                    ctx_next_o.ex_sel  = 1'b0;
                    ctx_next_o.ib_addr = ctx_last_i.ib_addr + ADDR_W'(1);
                end else begin
                    ctx_next_o.wb_sel  = 1'b1;
                    ctx_next_o.ex_sel  = 1'b1;
                end

                if (at_last && ctx_last_i.iter == '0) begin
                    ctx_next_o.state = IB_BACK;
                end else if (at_last) begin
                    ctx_next_o.state = UPDATE;
                end else begin
                    ctx_next_o.state = ML;
                end

                ctx_next_o.wb_w_addr = seg_inc(ctx_last_i.wb_w_addr);
                ctx_next_o.wb_r_addr = seg_inc(ctx_last_i.wb_r_addr);
                ctx_next_o.kb_r_addr = seg_inc(ctx_last_i.kb_r_addr);
                ctx_next_o.wb_wr     = 1'b1;
                ctx_next_o.ml_sel    = '0;
                ctx_next_o.update    = 1'b0;
                ctx_next_o.ml_clr    = 1'b0;
                ctx_next_o.cnt       = ctx_last_i.cnt + CNT_W'(1);
            end

            UPDATE: begin
                ctx_next_o.state     = ML;
                ctx_next_o.iter      = ctx_last_i.iter - CNT_W'(1);
                ctx_next_o.ib_addr   = ctx_last_i.ib_addr + ADDR_W'(1);
                ctx_next_o.wb_w_addr = seg_inc(ctx_last_i.wb_w_addr);
                ctx_next_o.wb_r_addr = seg_inc(ctx_last_i.wb_r_addr);
                ctx_next_o.kb_r_addr = seg_inc(ctx_last_i.kb_r_addr);
                ctx_next_o.wb_wr     = 1'b1;
                ctx_next_o.wb_sel    = 1'b0;
                ctx_next_o.ex_sel    = 1'b0;
                ctx_next_o.update    = 1'b1;
                ctx_next_o.ml_sel    = '0;
                ctx_next_o.ml_clr    = 1'b0;
                ctx_next_o.cnt       = ctx_last_i.cnt + CNT_W'(1);
            end

            IB_BACK: begin
                // one output word per step, lane follows the count
                ctx_next_o.state   = (ctx_last_i.cnt == OB_LAST) ? VALID : IB_BACK;
                ctx_next_o.ob_wr   = 1'b1;
                ctx_next_o.ob_addr = {ctx_last_i.ob_addr[ADDR_W-1:OB_SEG_W],
                                      ctx_last_i.cnt[OB_SEG_W-1:0]};
                ctx_next_o.ml_sel  = ctx_last_i.cnt[OB_SEG_W-1:0];
                ctx_next_o.wb_wr   = 1'b1;
                ctx_next_o.ex_sel  = 1'b0;
                ctx_next_o.update  = 1'b0;
                ctx_next_o.ml_clr  = 1'b0;
                ctx_next_o.cnt     = ctx_last_i.cnt + CNT_W'(1);
            end

            VALID: begin
                // hold result until start drops, then release at once
                valid_set_o       = start_i;
                valid_clr_o       = !start_i;
                ctx_next_o.state  = start_i ? VALID : IDLE;
                ctx_next_o.ob_wr  = 1'b0;
                ctx_next_o.wb_wr  = 1'b0;
                ctx_next_o.ex_sel = 1'b0;
                ctx_next_o.update = 1'b0;
                ctx_next_o.ml_clr = 1'b0;
            end

            default: begin
                ctx_next_o.state = IDLE;
            end
        endcase
    end

endmodule

//--- verilog/ctx_pkg.sv
package ctx_pkg;

    // ring and thread geometry
    localparam int NUM_THREADS = 4;
    localparam int PHASE_W     = 2;

    localparam int ADDR_W   = 10;
    localparam int CNT_W    = 6;
    localparam int WB_SEG_W = 6;
    localparam int OB_SEG_W = 3;

    // sweep counter landmarks
    localparam logic [CNT_W-1:0] SWEEP_LAST = CNT_W'(63);
    localparam logic [CNT_W-1:0] LOAD_LAST  = CNT_W'(14);
    localparam logic [CNT_W-1:0] OB_LAST    = CNT_W'(7);

    // per-thread buffer windows, low segment bits must stay zero
    localparam logic [ADDR_W-1:0] OB_BASE [NUM_THREADS] = '{
        10'h000, 10'h040, 10'h080, 10'h0c0
    };
    localparam logic [ADDR_W-1:0] WB_BASE [NUM_THREADS] = '{
        10'h000, 10'h100, 10'h200, 10'h300
    };

    typedef logic [PHASE_W-1:0] thread_t;

    typedef enum logic [2:0] {
        IDLE,
        START,
        CLEAR,
        ML,
        UPDATE,
        IB_BACK,
        VALID
    } ctx_state_e;

    // one job context, travels around the ring
    typedef struct packed {
        ctx_state_e          state;
        logic [CNT_W-1:0]    iter;
        logic [CNT_W-1:0]    cnt;
        logic [ADDR_W-1:0]   ib_addr;
        logic [ADDR_W-1:0]   ob_addr;
        logic                ob_wr;
        thread_t             ib_sel;
        logic [ADDR_W-1:0]   wb_w_addr;
        logic [ADDR_W-1:0]   wb_r_addr;
        logic                wb_wr;
        logic                wb_sel;
        logic [ADDR_W-1:0]   kb_r_addr;
        logic                ex_sel;
        logic [OB_SEG_W-1:0] ml_sel;
        logic                update;
        logic                ml_clr;
    } ctx_t;

    // idle context of a thread, controls low and windows at base
    function automatic ctx_t ctx_reset(thread_t tid);
        ctx_t c;
        c           = '0;
        c.state     = IDLE;
        c.ib_sel    = tid;
        c.ob_addr   = OB_BASE[tid];
        c.wb_w_addr = WB_BASE[tid];
        c.wb_r_addr = WB_BASE[tid];
        return c;
    endfunction

endpackage

//--- verilog/nn_ctrl_top.sv
`timescale 1ns/1ns

module nn_ctrl_top (
    input  logic                                           clk_i,
    input  logic                                           rst_ni,
    input  logic [ctx_pkg::NUM_THREADS-1:0]                start_i,
    input  logic [ctx_pkg::NUM_THREADS*ctx_pkg::CNT_W-1:0] iter_size_i,
    output logic [ctx_pkg::NUM_THREADS-1:0]                valid_o,
    output logic [ctx_pkg::ADDR_W-1:0]                     ob_addr_o,
    output logic [ctx_pkg::ADDR_W-1:0]                     ib_r_addr_o,
    output logic                                           ob_wr_o,
    output ctx_pkg::thread_t                               ib_r_sel_o,
    output logic [ctx_pkg::ADDR_W-1:0]                     wb_w_addr_o,
    output logic [ctx_pkg::ADDR_W-1:0]                     wb_r_addr_o,
    output logic                                           wb_wr_o,
    output logic                                           wb_sel_o,
    output logic [ctx_pkg::ADDR_W-1:0]                     kb_r_addr_o,
    output logic                                           ex_sel_o,
    output logic [ctx_pkg::OB_SEG_W-1:0]                   ml_sel_o,
    output logic                                           update_o,
    output logic                                           ml_clr_o
);

    import ctx_pkg::*;

    thread_t          phase;
    logic             start_cur;
    logic [CNT_W-1:0] iter_cur;
    logic             valid_set;
    logic             valid_clr;
    ctx_t             ctx_next;
    ctx_t             ctx_s0;
    ctx_t             ctx_s1;
    ctx_t             ctx_last;

    thread_sched i_sched (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .start_i     (start_i),
        .iter_size_i (iter_size_i),
        .valid_set_i (valid_set),
        .valid_clr_i (valid_clr),
        .phase_o     (phase),
        .start_o     (start_cur),
        .iter_size_o (iter_cur),
        .valid_o     (valid_o)
    );

    context_step i_step (
        .ctx_last_i  (ctx_last),
        .phase_i     (phase),
        .start_i     (start_cur),
        .iter_size_i (iter_cur),
        .ctx_next_o  (ctx_next),
        .valid_set_o (valid_set),
        .valid_clr_o (valid_clr)
    );

    context_ring i_ring (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .ctx_next_i (ctx_next),
        .ctx_s0_o   (ctx_s0),
        .ctx_s1_o   (ctx_s1),
        .ctx_last_o (ctx_last)
    );

    // read addresses leave a cycle ahead of the other outputs
    assign wb_r_addr_o = ctx_s0.wb_r_addr;
    assign kb_r_addr_o = ctx_s0.kb_r_addr;

    assign ob_addr_o   = ctx_s1.ob_addr;
    assign ib_r_addr_o = ctx_s1.ib_addr;
    assign ob_wr_o     = ctx_s1.ob_wr;
    assign ib_r_sel_o  = ctx_s1.ib_sel;
    assign wb_w_addr_o = ctx_s1.wb_w_addr;
    assign wb_wr_o     = ctx_s1.wb_wr;
    assign wb_sel_o    = ctx_s1.wb_sel;
    assign ex_sel_o    = ctx_s1.ex_sel;
    assign ml_sel_o    = ctx_s1.ml_sel;
    assign update_o    = ctx_s1.update;
    assign ml_clr_o    = ctx_s1.ml_clr;

    // write-back count stays inside the eight output words
    a_ob_cnt : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        ctx_last.state == IB_BACK |-> ctx_last.cnt <= OB_LAST
    );

    // output writes only come from write-back
    a_ob_wr : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        ctx_last.ob_wr |-> ctx_last.state inside {IB_BACK, VALID}
    );

endmodule

//--- verilog/thread_sched.sv
`timescale 1ns/1ns

module thread_sched (
    input  logic                                           clk_i,
    input  logic                                           rst_ni,
    input  logic [ctx_pkg::NUM_THREADS-1:0]                start_i,
    input  logic [ctx_pkg::NUM_THREADS*ctx_pkg::CNT_W-1:0] iter_size_i,
    input  logic                                           valid_set_i,
    input  logic                                           valid_clr_i,
    output ctx_pkg::thread_t                               phase_o,
    output logic                                           start_o,
    output logic [ctx_pkg::CNT_W-1:0]                      iter_size_o,
    output logic [ctx_pkg::NUM_THREADS-1:0]                valid_o
);

    import ctx_pkg::*;

    thread_t                phase_q;
    logic [NUM_THREADS-1:0] valid_q;

    // counts 3, 2, 1, 0 so stage k at reset belongs to thread k
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            phase_q <= thread_t'(NUM_THREADS - 1);
        end else begin
            phase_q <= phase_q - thread_t'(1);
        end
    end

    // strobes always refer to the thread stepped this cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else begin
            if (valid_set_i) begin
                valid_q[phase_q] <= 1'b1;
            end
            if (valid_clr_i) begin
                valid_q[phase_q] <= 1'b0;
            end
        end
    end

    assign phase_o     = phase_q;
    assign start_o     = start_i[phase_q];
    assign iter_size_o = iter_size_i[int'(phase_q)*CNT_W +: CNT_W];
    assign valid_o     = valid_q;

    // step logic holds one state per thread, so never both
    a_strobe_excl : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        !(valid_set_i && valid_clr_i)
    );

endmodule
